/* all.f */
design/OpLoadPkg.sv
design/OneHotEncoder.sv
design/PhysRegFile.sv
design/PcFile.sv
design/OperandLoad.sv
design/OpLoadTop.sv
dv/OperandLoad_assert.sv
dv/OpLoadTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= OpLoadTb
OBJ_DIR ?= obj_dir
FILELIST ?= all.f
VFLAGS ?= --binary --timing --assert -j 0
SIMFLAGS ?= +verilator+error+limit+100
PASS_MSG ?= All checks passed

SRCS := $(shell cat $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIMFLAGS) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

/* dv/OpLoadTb.sv */
`timescale 1ns/1ps

module OpLoadTb;
    import OpLoadPkg::*;

    logic clk = 1'b0;
    logic rst = 1'b1;
    IssueUop [NumPorts-1:0] issue = '0;
    WbResult [NumWbs-1:0] wb = '0;
    ZcForward [NumZcFwds-1:0] zcFwd = '0;
    BranchFlush branch = '0;
    logic [NumPorts-1:0] stall = '0;
    PcFileWrite pcWrite = '0;
    ExUop [NumPorts-1:0] exUop;

    // Inputs for the next edge, applied by step()
    IssueUop [NumPorts-1:0] nIssue = '0;
    WbResult [NumWbs-1:0] nWb = '0;
    ZcForward [NumZcFwds-1:0] nZc = '0;
    BranchFlush nBranch = '0;
    logic [NumPorts-1:0] nStall = '0;
    PcFileWrite nPcw = '0;

    Word shadowRegs [NumPhysRegs] = '{default: '0};
    PcFileEntry shadowPc [NumFetchIds] = '{default: '0};
    ExUop [NumPorts-1:0] held = '0;
    ExUop [NumPorts-1:0] want = '0;
    ExUop [NumPorts-1:0] wantD;
    logic checkOn = 1'b0;
    logic checkD;
    string testName = "reset";
    int errors = 0;
    int cycles = 0;
    int tests = 0;
    int lastFails = 0;

    OpLoadTop dut0 (.*);

    always #2 clk = ~clk;

    always_ff @(posedge clk) begin
        if (rst) begin
            checkD <= 1'b0;
        end else begin
            checkD <= checkOn;
        end
        wantD <= want;
    end

    function automatic logic sameUop(ExUop act, ExUop exp);
        return exp.valid ? act == exp : !act.valid;
    endfunction

    for (genvar p = 0; p < NumPorts; p++) begin : gCheck
        assert property (@(posedge clk) disable iff (rst) checkD |-> sameUop(exUop[p], wantD[p]))
            else begin
                $display("FAIL %s port %0d: expected %h, actual %h", testName, p,
                    $sampled(wantD[p]), $sampled(exUop[p]));
                errors++;
            end
    end

    // Run limit covers six tests of up to 400 cycles with margin
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 4000) begin
            $display("Timeout: the run did not finish within %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic younger(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

    function automatic Word signExt(logic [5:0] v);
        return Word'($signed(v));
    endfunction

    // Zero-cycle forward beats writeback 0, which beats writeback 1 and the array
    function automatic Word regValue(RfIdx idx, output logic hit);
        Word val;
        hit = 1'b1;
        val = shadowRegs[idx];
        if (nZc[0].valid && nZc[0].tag == idx) begin
            val = nZc[0].result;
        end else if (nWb[0].valid && nWb[0].tagDst == idx) begin
            val = nWb[0].result;
        end else if (nWb[1].valid && nWb[1].tagDst == idx) begin
            val = nWb[1].result;
        end else begin
            hit = 1'b0;
        end
        return val;
    endfunction

    function automatic Word operand(OperandTag tag, logic useImm, Word imm);
        logic hit;
        Word val;
        if (tag.constTag.isConst) begin
            return signExt(tag.constTag.value);
        end
        val = regValue(tag.regTag.idx, hit);
        return (useImm && !hit) ? imm : val;
    endfunction

    function automatic ExUop expectUop(IssueUop u, int port);
        ExUop e;
        PcFileEntry pe;
        pe = shadowPc[u.fetchId];
        e.valid = 1'b1;
        e.sqN = u.sqN;
        e.tagDst = u.tagDst;
        e.srcA = operand(u.tagA, 1'b0, u.imm);
        e.srcB = port < NumAluPorts ? operand(u.tagB, u.immB, u.imm) : u.imm;
        e.imm = u.imm;
        e.pc = {pe.blockPc, u.fetchOffs, 1'b0};
        e.fetchStartOffs = pe.blockPc[2:0];
        e.predTaken = pe.predTaken && pe.branchPos == u.fetchOffs;
        e.opcode = u.opcode;
        return e;
    endfunction

    function automatic IssueUop randomUop();
        logic [95:0] bits;
        IssueUop u;
        bits = {$urandom(), $urandom(), $urandom()};
        u = bits[$bits(IssueUop)-1:0];
        u.valid = 1'b1;
        return u;
    endfunction

    function automatic IssueUop regUop(RfIdx r);
        IssueUop u;
        u = randomUop();
        u.tagA = {1'b0, r};
        u.tagB = {1'b0, r};
        u.immB = 1'b0;
        return u;
    endfunction

    task automatic issueNear(SqN base);
        for (int p = 0; p < NumPorts; p++) begin
            nIssue[p] = randomUop();
            nIssue[p].sqN = base + SqN'($urandom_range(15)) - SqN'(8);
        end
    endtask

    // Advance the model by one edge, then drive the staged inputs
    task automatic step();
        @(posedge clk);
        for (int p = 0; p < NumPorts; p++) begin
            if (nStall[p]) begin
                if (nBranch.taken && younger(held[p].sqN, nBranch.sqN)) begin
                    held[p].valid = 1'b0;
                end
            end else if (nIssue[p].valid
                    && !(nBranch.taken && younger(nIssue[p].sqN, nBranch.sqN))) begin
                held[p] = expectUop(nIssue[p], p);
            end else begin
                held[p].valid = 1'b0;
            end
        end
        for (int i = 0; i < NumWbs; i++) begin
            if (nWb[i].valid) begin
                shadowRegs[nWb[i].tagDst] = nWb[i].result;
            end
        end
        if (nPcw.valid) begin
            shadowPc[nPcw.fetchId] = nPcw.entry;
        end
        issue <= nIssue;
        wb <= nWb;
        zcFwd <= nZc;
        branch <= nBranch;
        stall <= nStall;
        pcWrite <= nPcw;
        want <= held;
        checkOn <= 1'b1;
        nIssue = '0;
        nWb = '0;
        nZc = '0;
        nBranch = '0;
        nPcw = '0;
    endtask

    task automatic endTest();
        int failures;
        nStall = '0;
        repeat (3) step();
        failures = errors + dut0.checks0.violations - lastFails;
        lastFails += failures;
        tests++;
        $display("Test %s finished with %0d failing checks", testName, failures);
    endtask

    initial begin
        RfIdx r;
        SqN base;
        int total;
        void'($urandom(32'h21e2));
        // Valid uops offered during reset must not come out of it
        @(posedge clk);
        for (int p = 0; p < NumPorts; p++) begin
            issue[p].valid <= 1'b1;
        end
        repeat (15) @(posedge clk);
        rst <= 1'b0;
        issue <= '0;

        testName = "consts";
        for (int i = 0; i < 20; i++) begin
            nIssue[0] = randomUop();
            nIssue[0].tagA.constTag.isConst = 1'b1;
            nIssue[0].tagB.constTag.isConst = i[0];
            nIssue[0].immB = 1'b1;
            nIssue[1] = randomUop();
            nIssue[1].tagA.constTag.isConst = 1'b1;
            step();
        end
        endTest();

        testName = "regfile";
        for (int i = 0; i < 32; i++) begin
            nWb[0] = '{1'b1, RfIdx'(2 * i), $urandom()};
            nWb[1] = '{1'b1, RfIdx'(2 * i + 1), $urandom()};
            step();
        end
        for (int i = 0; i < 24; i++) begin
            nIssue[0] = regUop(RfIdx'($urandom()));
            nIssue[0].tagB.regTag.idx = RfIdx'($urandom());
            nIssue[1] = regUop(RfIdx'($urandom()));
            step();
        end
        endTest();

        testName = "forward";
        for (int i = 0; i < 24; i++) begin
            r = RfIdx'($urandom());
            // Writeback 0 misses on some rounds so writeback 1 forwards alone
            nWb[0] = '{1'b1, i[2] ? RfIdx'(r + 1) : r, $urandom()};
            nWb[1] = '{i[1], r, $urandom()};
            nZc[0] = '{i[0], r, $urandom()};
            nIssue[0] = regUop(r);
            nIssue[1] = regUop(r);
            step();
        end
        endTest();

        testName = "stall";
        for (int i = 0; i < 4; i++) begin
            r = RfIdx'($urandom());
            nIssue[0] = regUop(r);
            nIssue[1] = regUop(r);
            step();
            nStall = 2'(i % 3 + 1);
            for (int k = 0; k < 5; k++) begin
                nWb[0] = '{1'b1, r, $urandom()};
                nIssue[0] = randomUop();
                nIssue[1] = randomUop();
                step();
            end
            nStall = '0;
            nIssue[0] = randomUop();
            nIssue[0].valid = i[0];
            nIssue[1] = randomUop();
            nIssue[1].valid = !i[0];
            step();
        end
        endTest();

        // Bases straddle the sequence number wrap
        testName = "flush";
        for (int i = 0; i < 16; i++) begin
            base = SqN'(56 + i);
            issueNear(base);
            step();
            nStall = {2{i[0]}};
            nBranch = '{1'b1, base};
            issueNear(base);
            step();
            nStall = '0;
            step();
        end
        endTest();

        testName = "pcfile";
        for (int i = 0; i < NumFetchIds; i++) begin
            nPcw = '{1'b1, FetchId'(i),
                '{BlockPc'($urandom()), FetchOff'($urandom()), i[0]}};
            step();
        end
        for (int i = 0; i < 24; i++) begin
            for (int p = 0; p < NumPorts; p++) begin
                nIssue[p] = randomUop();
                if (i[1]) begin
                    nIssue[p].fetchOffs = shadowPc[nIssue[p].fetchId].branchPos;
                end
            end
            step();
        end
        endTest();

        total = errors + dut0.checks0.violations;
        $display("%0d tests run, %0d failing checks in total", tests, total);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* dv/OperandLoad_assert.sv */
`timescale 1ns/1ps

module OpLoadProtocolChecks (
    input logic clk,
    input logic rst,
    input OpLoadPkg::BranchFlush branch,
    input logic [OpLoadPkg::NumPorts-1:0] stall,
    input OpLoadPkg::ExUop [OpLoadPkg::NumPorts-1:0] exUop
);
    import OpLoadPkg::*;

    int violations = 0;

    function automatic logic youngerThan(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

    for (genvar p = 0; p < NumPorts; p++) begin : gPort
        assert property (@(posedge clk) $fell(rst) |-> !exUop[p].valid)
            else begin
                $error("exUop on port %0d is valid right after reset", p);
                violations++;
            end

        // A branch in the same cycle may legally drop the held uop
        assert property (@(posedge clk) disable iff (rst)
            !$past(rst) && $past(stall[p]) && !$past(branch.taken) |-> $stable(exUop[p]))
            else begin
                $error("exUop on port %0d changed while the port was stalled", p);
                violations++;
            end

        assert property (@(posedge clk) disable iff (rst)
            $past(branch.taken) && exUop[p].valid
                |-> !youngerThan(exUop[p].sqN, $past(branch.sqN)))
            else begin
                $error("exUop on port %0d is younger than a taken branch", p);
                violations++;
            end
    end

endmodule

bind OpLoadTop OpLoadProtocolChecks checks0 (.clk(clk), .rst(rst), .branch(branch), .stall(stall), .exUop(exUop));

/* design/OpLoadTop.sv */
`timescale 1ns/1ps

module OpLoadTop (
    input  logic clk,
    input  logic rst,
    input  OpLoadPkg::IssueUop [OpLoadPkg::NumPorts-1:0] issue,
    input  OpLoadPkg::WbResult [OpLoadPkg::NumWbs-1:0] wb,
    input  OpLoadPkg::ZcForward [OpLoadPkg::NumZcFwds-1:0] zcFwd,
    input  OpLoadPkg::BranchFlush branch,
    input  logic [OpLoadPkg::NumPorts-1:0] stall,
    input  OpLoadPkg::PcFileWrite pcWrite,
    output OpLoadPkg::ExUop [OpLoadPkg::NumPorts-1:0] exUop
);
    import OpLoadPkg::*;

    RfReadReq [NumRfReads-1:0] rfRead;
    Word [NumRfReads-1:0] rfData;
    PcReadReq [NumPorts-1:0] pcRead;
    PcFileEntry [NumPorts-1:0] pcData;

    OperandLoad load0 (
        .clk(clk),
        .rst(rst),
        .issue(issue),
        .wb(wb),
        .zcFwd(zcFwd),
        .branch(branch),
        .stall(stall),
        .rfRead(rfRead),
        .rfData(rfData),
        .pcRead(pcRead),
        .pcData(pcData),
        .exUop(exUop)
    );

    // Writebacks are both snooped by the stage and written here
    PhysRegFile rf0 (
        .clk(clk),
        .rst(rst),
        .wb(wb),
        .rfRead(rfRead),
        .rfData(rfData)
    );

    PcFile pcf0 (
        .clk(clk),
        .rst(rst),
        .pcWrite(pcWrite),
        .pcRead(pcRead),
        .pcData(pcData)
    );

endmodule

/* design/OperandLoad.sv */
`timescale 1ns/1ps

module OperandLoad (
    input  logic clk,
    input  logic rst,
    input  OpLoadPkg::IssueUop [OpLoadPkg::NumPorts-1:0] issue,
    input  OpLoadPkg::WbResult [OpLoadPkg::NumWbs-1:0] wb,
    input  OpLoadPkg::ZcForward [OpLoadPkg::NumZcFwds-1:0] zcFwd,
    input  OpLoadPkg::BranchFlush branch,
    input  logic [OpLoadPkg::NumPorts-1:0] stall,
    output OpLoadPkg::RfReadReq [OpLoadPkg::NumRfReads-1:0] rfRead,
    input  OpLoadPkg::Word [OpLoadPkg::NumRfReads-1:0] rfData,
    output OpLoadPkg::PcReadReq [OpLoadPkg::NumPorts-1:0] pcRead,
    input  OpLoadPkg::PcFileEntry [OpLoadPkg::NumPorts-1:0] pcData,
    output OpLoadPkg::ExUop [OpLoadPkg::NumPorts-1:0] exUop
);
    import OpLoadPkg::*;

    function automatic Word constValue(OperandTag tag);
        return {{($bits(Word) - 6){tag.constTag.value[5]}}, tag.constTag.value};
    endfunction

    // Sequence numbers wrap, so age is the sign of the difference
    function automatic logic isYounger(SqN a, SqN b);
        logic signed [$bits(SqN)-1:0] diff;
        diff = a - b;
        return diff > 0;
    endfunction

    ZcForward [NumFwd-1:0] fwd;
    OperandTag [NumRfReads-1:0] lookup;
    logic [NumRfReads-1:0][NumFwd-1:0] match;
    FwdIdx [NumRfReads-1:0] matchIdx;
    logic [NumRfReads-1:0] matchHit;

    Word [NumPorts-1:0] selA;
    Word [NumPorts-1:0] selB;
    logic [NumPorts-1:0][1:0] selIsReg;
    logic [NumPorts-1:0] accept;
    logic [NumPorts-1:0] flushHeld;

    ExUop [NumPorts-1:0] uopReg;
    logic [NumPorts-1:0][1:0] isReg;

    // Zero-cycle forwards first, they win over writebacks
    always_comb begin
        for (int i = 0; i < NumZcFwds; i++) begin
            fwd[i] = zcFwd[i];
        end
        for (int i = 0; i < NumWbs; i++) begin
            fwd[NumZcFwds + i].valid = wb[i].valid;
            fwd[NumZcFwds + i].tag = wb[i].tagDst;
            fwd[NumZcFwds + i].result = wb[i].result;
        end
    end

    // Lookup slots follow the read port layout: tagA per port, then tagB of ALU ports
    always_comb begin
        for (int p = 0; p < NumPorts; p++) begin
            lookup[p] = issue[p].tagA;
        end
        for (int p = 0; p < NumAluPorts; p++) begin
            lookup[NumPorts + p] = issue[p].tagB;
        end
        for (int i = 0; i < NumRfReads; i++) begin
            for (int j = 0; j < NumFwd; j++) begin
                match[i][j] = fwd[j].valid && !lookup[i].regTag.isConst
                    && fwd[j].tag == lookup[i].regTag.idx;
            end
        end
    end

    for (genvar i = 0; i < NumRfReads; i++) begin : gEnc
        OneHotEncoder enc (
            .match(match[i]),
            .idx(matchIdx[i]),
            .hit(matchHit[i])
        );
    end

    // No reads from a stalled port, so the held read data stays put
    always_comb begin
        for (int i = 0; i < NumRfReads; i++) begin
            rfRead[i].idx = lookup[i].regTag.idx;
        end
        for (int p = 0; p < NumPorts; p++) begin
            rfRead[p].valid = issue[p].valid && !stall[p] && !issue[p].tagA.regTag.isConst;
            pcRead[p].valid = issue[p].valid && !stall[p];
            pcRead[p].fetchId = issue[p].fetchId;
        end
        for (int p = 0; p < NumAluPorts; p++) begin
            rfRead[NumPorts + p].valid = issue[p].valid && !stall[p]
                && !issue[p].tagB.regTag.isConst;
        end
    end

    // Operand source selection
    always_comb begin
        for (int p = 0; p < NumPorts; p++) begin
            selIsReg[p] = 2'b00;
            selB[p] = issue[p].imm;
            if (issue[p].tagA.regTag.isConst) begin
                selA[p] = constValue(issue[p].tagA);
            end else if (matchHit[p]) begin
                selA[p] = fwd[matchIdx[p]].result;
            end else begin
                selA[p] = '0;
                selIsReg[p][0] = 1'b1;
            end
        end
        // AGU ports keep the immediate as srcB
        for (int p = 0; p < NumAluPorts; p++) begin
            if (issue[p].tagB.regTag.isConst) begin
                selB[p] = constValue(issue[p].tagB);
            end else if (matchHit[NumPorts + p]) begin
                selB[p] = fwd[matchIdx[NumPorts + p]].result;
            end else if (!issue[p].immB) begin
                selIsReg[p][1] = 1'b1;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < NumPorts; p++) begin
            accept[p] = issue[p].valid && !stall[p]
                && !(branch.taken && isYounger(issue[p].sqN, branch.sqN));
            flushHeld[p] = uopReg[p].valid && branch.taken
                && isYounger(uopReg[p].sqN, branch.sqN);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < NumPorts; p++) begin
                uopReg[p].valid <= 1'b0;
                isReg[p] <= 2'b00;
            end
        end else begin
            for (int p = 0; p < NumPorts; p++) begin
                if (accept[p]) begin
                    uopReg[p].valid <= 1'b1;
                    uopReg[p].sqN <= issue[p].sqN;
                    uopReg[p].tagDst <= issue[p].tagDst;
                    uopReg[p].srcA <= selA[p];
                    uopReg[p].srcB <= selB[p];
                    uopReg[p].imm <= issue[p].imm;
                    // Low PC bits are known now, the block PC joins on output
                    uopReg[p].pc <= {{($bits(BlockPc)){1'b0}}, issue[p].fetchOffs, 1'b0};
                    uopReg[p].fetchStartOffs <= '0;
                    uopReg[p].predTaken <= 1'b0;
                    uopReg[p].opcode <= issue[p].opcode;
                    isReg[p] <= selIsReg[p];
                end else if (!stall[p] || flushHeld[p]) begin
                    uopReg[p].valid <= 1'b0;
                    isReg[p] <= 2'b00;
                end else begin
                    // Capture register values once so later writes cannot leak in
                    uopReg[p].srcA <= exUop[p].srcA;
                    uopReg[p].srcB <= exUop[p].srcB;
                    isReg[p] <= 2'b00;
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < NumPorts; p++) begin
            exUop[p] = uopReg[p];
            if (isReg[p][0]) begin
                exUop[p].srcA = rfData[p];
            end
            exUop[p].pc = {pcData[p].blockPc, uopReg[p].pc[BlockOffW-1:0]};
            exUop[p].fetchStartOffs = pcData[p].blockPc[$bits(FetchOff)-1:0];
            // Prediction only belongs to the uop at the predicted branch slot
            exUop[p].predTaken = pcData[p].predTaken
                && uopReg[p].pc[BlockOffW-1:1] == pcData[p].branchPos;
        end
        for (int p = 0; p < NumAluPorts; p++) begin
            if (isReg[p][1]) begin
                exUop[p].srcB = rfData[NumPorts + p];
            end
        end
    end

endmodule

/* design/PcFile.sv */
`timescale 1ns/1ps

module PcFile (
    input  logic clk,
    input  logic rst,
    input  OpLoadPkg::PcFileWrite pcWrite,
    input  OpLoadPkg::PcReadReq [OpLoadPkg::NumPorts-1:0] pcRead,
    output OpLoadPkg::PcFileEntry [OpLoadPkg::NumPorts-1:0] pcData
);
    import OpLoadPkg::*;

    PcFileEntry entries [NumFetchIds];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NumFetchIds; i++) begin
                entries[i] <= '0;
            end
        end else if (pcWrite.valid) begin
            entries[pcWrite.fetchId] <= pcWrite.entry;
        end
    end

    // One read per issue port
    always_ff @(posedge clk) begin
        for (int i = 0; i < NumPorts; i++) begin
            if (pcRead[i].valid) begin
                pcData[i] <= entries[pcRead[i].fetchId];
            end
        end
    end

endmodule

/* design/PhysRegFile.sv */
`timescale 1ns/1ps

module PhysRegFile (
    input  logic clk,
    input  logic rst,
    input  OpLoadPkg::WbResult [OpLoadPkg::NumWbs-1:0] wb,
    input  OpLoadPkg::RfReadReq [OpLoadPkg::NumRfReads-1:0] rfRead,
    output OpLoadPkg::Word [OpLoadPkg::NumRfReads-1:0] rfData
);
    import OpLoadPkg::*;

    Word regs [NumPhysRegs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NumPhysRegs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // Higher bus number is written last and wins
            for (int i = 0; i < NumWbs; i++) begin
                if (wb[i].valid) begin
                    regs[wb[i].tagDst] <= wb[i].result;
                end
            end
        end
    end

    // Read data holds until the next valid request on that port
    always_ff @(posedge clk) begin
        for (int i = 0; i < NumRfReads; i++) begin
            if (rfRead[i].valid) begin
                rfData[i] <= regs[rfRead[i].idx];
            end
        end
    end

endmodule

/* design/OneHotEncoder.sv */
`timescale 1ns/1ps

module OneHotEncoder (
    input  logic [OpLoadPkg::NumFwd-1:0] match,
    output OpLoadPkg::FwdIdx idx,
    output logic hit
);
    import OpLoadPkg::*;

    // Scan downward so the lowest set bit is the one left standing
    always_comb begin
        idx = '0;
        for (int i = NumFwd - 1; i >= 0; i--) begin
            if (match[i]) begin
                idx = FwdIdx'(i);
            end
        end
    end

    assign hit = |match;

endmodule

/* design/OpLoadPkg.sv */
package OpLoadPkg;

    localparam int NumPorts = 2;
    localparam int NumAluPorts = 1;
    localparam int NumWbs = 2;
    localparam int NumZcFwds = 1;
    localparam int NumRfReads = NumAluPorts * 2 + (NumPorts - NumAluPorts);
    localparam int NumFwd = NumZcFwds + NumWbs;
    localparam int NumPhysRegs = 64;
    localparam int NumFetchIds = 8;
    localparam int FwdIdxW = $clog2(NumFwd);

    // 16-byte fetch blocks, addressed in half-words
    localparam int BlockOffW = 4;

    typedef logic [31:0] Word;
    typedef logic [$clog2(NumPhysRegs)-1:0] RfIdx;
    typedef logic [$clog2(NumFetchIds)-1:0] FetchId;
    typedef logic [BlockOffW-2:0] FetchOff;
    typedef logic [5:0] SqN;
    typedef logic [5:0] Opcode;
    typedef logic [FwdIdxW-1:0] FwdIdx;
    typedef logic [31-BlockOffW:0] BlockPc;

    typedef struct packed {
        logic isConst;
        RfIdx idx;
    } RegTag;

    // Value is sign-extended to a full word on use
    typedef struct packed {
        logic isConst;
        logic signed [5:0] value;
    } ConstTag;

    typedef union packed {
        RegTag regTag;
        ConstTag constTag;
    } OperandTag;

    typedef struct packed {
        logic valid;
        SqN sqN;
        OperandTag tagA;
        OperandTag tagB;
        RfIdx tagDst;
        logic immB;
        Word imm;
        FetchId fetchId;
        FetchOff fetchOffs;
        Opcode opcode;
    } IssueUop;

    typedef struct packed {
        logic valid;
        SqN sqN;
        RfIdx tagDst;
        Word srcA;
        Word srcB;
        Word imm;
        Word pc;
        FetchOff fetchStartOffs;
        logic predTaken;
        Opcode opcode;
    } ExUop;

    typedef struct packed {
        logic valid;
        RfIdx tag;
        Word result;
    } ZcForward;

    typedef struct packed {
        logic valid;
        RfIdx tagDst;
        Word result;
    } WbResult;

    typedef struct packed {
        logic taken;
        SqN sqN;
    } BranchFlush;

    typedef struct packed {
        BlockPc blockPc;
        FetchOff branchPos;
        logic predTaken;
    } PcFileEntry;

    typedef struct packed {
        logic valid;
        FetchId fetchId;
        PcFileEntry entry;
    } PcFileWrite;

    typedef struct packed {
        logic valid;
        RfIdx idx;
    } RfReadReq;

    typedef struct packed {
        logic valid;
        FetchId fetchId;
    } PcReadReq;

endpackage
